// ==== aer_if.f ====
verilog/aer_if_pkg.sv
verilog/aer_if_control.sv
verilog/aer_in_sync.sv
verilog/aer_pkt_builder.sv
verilog/aer_if_top.sv
dv/aer_if_properties.sv
dv/aer_if_tb.sv

// ==== dv/aer_if_properties.sv ====
/*
 * protocol checks on the bridge ports, bound into the top level
 */
`timescale 1ns/1ns
`default_nettype none

module aer_if_properties (
  input wire                   clk,
  input wire                   rst,
  input wire                   aer_req_n,
  input wire                   aer_ack_n,
  input wire aer_if_pkg::pkt_t opkt_data,
  input wire                   opkt_vld,
  input wire                   opkt_rdy,
  input wire                   cpkt_rdy
);

  // ----------------------------------------
  // AER handshake
  // ----------------------------------------

  // ack may only answer a pending request
  property ack_needs_req;
    @(posedge clk) disable iff (rst) $fell(aer_ack_n) |-> !aer_req_n;
  endproperty

  // ----------------------------------------
  // packet link
  // ----------------------------------------

  // stalled packet holds still until taken
  property opkt_stable;
    @(posedge clk) disable iff (rst)
      opkt_vld && !opkt_rdy |=> opkt_vld && $stable(opkt_data);
  endproperty

  // outputs quiet once reset has settled
  property reset_quiet;
    @(posedge clk) rst && $past(rst) |-> !cpkt_rdy && !opkt_vld;
  endproperty

  ack_needs_req_a: assert property (ack_needs_req) else $error("ack fell with request high");
  opkt_stable_a:   assert property (opkt_stable) else $error("packet changed while stalled");
  reset_quiet_a:   assert property (reset_quiet) else $error("ready or valid high in reset");

endmodule

bind aer_if_top aer_if_properties u_properties (.*);

`default_nettype wire

// ==== dv/aer_if_tb.sv ====
/*
 * AER bridge testbench: AER sender, stalling packet sink,
 * control packet driver and an ordered packet scoreboard
 */
`timescale 1ns/1ns
`default_nettype none

module aer_if_tb;

  import aer_if_pkg::*;

  localparam int SEED         = 16254;
  localparam int RESET_CYCLES = 8;
  localparam int STALL_CYCLES = 100;
  // event budget times cycles per event, doubled for margin
  localparam int TIMEOUT_CYCLES = 250 * 40 * 2;

  logic      clk = 1'b0;
  logic      rst;
  logic      aer_req_n;
  aer_addr_t aer_addr;
  logic      aer_ack_n;
  pkt_t      cpkt_data;
  logic      cpkt_vld;
  logic      cpkt_rdy;
  mode_t     msel;
  vks_t      vksel;
  pkt_t      opkt_data;
  logic      opkt_vld;
  logic      opkt_rdy = 1'b0;

  // scoreboard state
  pkt_t        exp_q[$];
  logic        go_model;
  string       test_name;
  logic        stall_hold;
  logic        ack_d = 1'b1;
  int          stall_acks = 0;
  int          cycles = 0;
  logic [31:0] addr_state;
  logic [31:0] rdy_state = SEED;

  aer_if_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .aer_req_n (aer_req_n),
    .aer_addr  (aer_addr),
    .aer_ack_n (aer_ack_n),
    .cpkt_data (cpkt_data),
    .cpkt_vld  (cpkt_vld),
    .cpkt_rdy  (cpkt_rdy),
    .msel      (msel),
    .vksel     (vksel),
    .opkt_data (opkt_data),
    .opkt_vld  (opkt_vld),
    .opkt_rdy  (opkt_rdy)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic aer_addr_t next_addr();
    addr_state = lcg_step(addr_state);
    return addr_state[31:16];
  endfunction

  // expected packet straight from the mapping rules
  function automatic pkt_t expect_pkt(input aer_addr_t a, input mode_t m, input vks_t vs);
    logic [15:0] top;
    logic [15:0] low;
    top = (vs == VKS_ALT) ? VKEY_ALT : VKEY_DEF;
    // retina: y above x, polarity at bit 0, top bit clear
    if (m == MODE_RETINA)
      low = {1'b0, a[13:7], a[6:0], a[14]};
    else
      low = a;
    return {top, low, MC_HEADER};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic compare_val(input string test, input logic [39:0] exp, input logic [39:0] act);
    assert (act === exp) else
      abort_run($sformatf("ERR %s expected %h actual %h", test, exp, act));
  endtask

  task automatic verify_reset_outputs(input string test);
    compare_val({test, "_ack_n"}, 40'd1, 40'(aer_ack_n));
    compare_val({test, "_opkt_vld"}, 40'd0, 40'(opkt_vld));
    compare_val({test, "_cpkt_rdy"}, 40'd0, 40'(cpkt_rdy));
  endtask

  // 4-phase sender, address one edge ahead of the request
  task automatic send_event(input aer_addr_t addr);
    @(posedge clk);
    aer_addr <= addr;
    if (go_model)
      exp_q.push_back(expect_pkt(addr, msel, vksel));
    @(posedge clk);
    aer_req_n <= 1'b0;
    while (aer_ack_n) @(posedge clk);
    aer_req_n <= 1'b1;
    while (!aer_ack_n) @(posedge clk);
  endtask

  // control packet, other bits random so only the go bit counts
  task automatic send_ctrl(input logic go_val);
    pkt_t        pkt;
    logic [47:0] rnd;
    rnd = {next_addr(), next_addr(), next_addr()};
    pkt = rnd[39:0];
    pkt[GO_BIT] = go_val;
    @(posedge clk);
    cpkt_data <= pkt;
    cpkt_vld  <= 1'b1;
    @(posedge clk);
    while (!cpkt_rdy) @(posedge clk);
    cpkt_vld <= 1'b0;
    go_model = go_val;
  endtask

  task automatic drain_packets();
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  // ----------------------------------------
  // sink, monitor and watchdog
  // ----------------------------------------

  // random ready, roughly half the cycles stalled
  always @(posedge clk) begin
    rdy_state = lcg_step(rdy_state);
    if (rst || stall_hold)
      opkt_rdy <= 1'b0;
    else
      opkt_rdy <= rdy_state[20];
  end

  always @(posedge clk) begin
    if (!rst && opkt_vld && opkt_rdy) begin
      assert (exp_q.size() != 0) else
        abort_run($sformatf("unexpected packet %h during %s", opkt_data, test_name));
      compare_val(test_name, exp_q.pop_front(), opkt_data);
    end
  end

  // count acks handed out while the sink is held off
  always @(posedge clk) begin
    ack_d <= aer_ack_n;
    if (stall_hold && ack_d && !aer_ack_n)
      stall_acks <= stall_acks + 1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
      abort_run($sformatf("timeout after %0d cycles in %s with %0d packets outstanding",
                          cycles, test_name, exp_q.size()));
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    rst        = 1'b1;
    aer_req_n  = 1'b1;
    aer_addr   = '0;
    cpkt_data  = '0;
    cpkt_vld   = 1'b0;
    msel       = MODE_RAW;
    vksel      = 1'b0;
    stall_hold = 1'b0;
    go_model   = INIT_GO;
    addr_state = SEED;
    test_name  = "reset";

    // first edge loads the reset values
    @(posedge clk);
    repeat (RESET_CYCLES - 1) begin
      @(posedge clk);
      verify_reset_outputs("reset_hold");
    end
    rst <= 1'b0;
    @(posedge clk);
    verify_reset_outputs("reset_release");
    @(posedge clk);
    compare_val("reset_cpkt_rdy_up", 40'd1, 40'(cpkt_rdy));

    // no control packet yet, relies on go out of reset
    test_name = "raw_default";
    repeat (50) send_event(next_addr());
    drain_packets();

    test_name = "retina_alt";
    msel  <= MODE_RETINA;
    vksel <= VKS_ALT;
    repeat (50) send_event(next_addr());
    drain_packets();

    // gated events still complete their handshake
    test_name = "go_gating";
    msel  <= MODE_RAW;
    vksel <= 1'b0;
    send_ctrl(1'b0);
    repeat (20) send_event(next_addr());
    compare_val("go_gating_idle", 40'd0, 40'(opkt_vld));
    test_name = "go_resume";
    send_ctrl(1'b1);
    repeat (10) send_event(next_addr());
    drain_packets();

    // one packet in the builder, the next held in the receiver
    test_name = "backpressure";
    stall_hold <= 1'b1;
    fork
      begin
        repeat (STALL_CYCLES) @(posedge clk);
        compare_val("backpressure_acks", 40'd1, 40'(stall_acks));
        compare_val("backpressure_held_ack_n", 40'd1, 40'(aer_ack_n));
        stall_hold <= 1'b0;
      end
      begin
        repeat (3) send_event(next_addr());
      end
    join
    drain_packets();

    if (exp_q.size() == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      abort_run("packets still outstanding at end of run");
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the AER bridge testbench with Verilator
# the run fails if the log holds the fail message

LOG=sim.log

verilator --binary --assert -f aer_if.f --top-module aer_if_tb -o aer_if_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/aer_if_sim > "$LOG" 2>&1

grep -q "TEST FAILED" "$LOG" && { echo "simulation failed, see $LOG"; exit 1; }
grep -q "TEST OK" "$LOG" || { echo "simulation ended without a pass line"; exit 1; }
echo "simulation passed"

// ==== verilog/aer_if_control.sv ====
/*
 * bridge control: go flag from control packets,
 * virtual key decode and mapping mode pass-through
 */
`timescale 1ns/1ns
`default_nettype none

module aer_if_control (
  input  wire                     clk,
  input  wire                     rst,

  // control packet link
  input  wire aer_if_pkg::pkt_t   cpkt_data,
  input  wire                     cpkt_vld,
  output logic                    cpkt_rdy,

  // static selects
  input  wire aer_if_pkg::mode_t  msel,
  input  wire aer_if_pkg::vks_t   vksel,

  // to packet builder
  output aer_if_pkg::mode_t       vmode,
  output aer_if_pkg::vkey_t       vkey,
  output logic                    go
);

  import aer_if_pkg::*;

  // ----------------------------------------
  // control link ready
  // ----------------------------------------

  // low through reset, then always ready
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      cpkt_rdy <= 1'b0;
    else
      cpkt_rdy <= 1'b1;
  end

  // ----------------------------------------
  // go flag
  // ----------------------------------------

  // updated only on an accepted control packet
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      go <= INIT_GO;
    else if (cpkt_vld && cpkt_rdy)
      go <= cpkt_data[GO_BIT];
  end

  // mode goes straight through
  always_comb vmode = msel;

  // key select decode
  always_comb begin
    case (vksel)
      VKS_ALT: vkey = VKEY_ALT;
      default: vkey = VKEY_DEF;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/aer_if_pkg.sv ====
/*
 * AER to SpiNNaker bridge shared types and constants
 * packet layout, key parts, mapping modes and control defaults
 */
`default_nettype none

package aer_if_pkg;

  // ----------------------------------------
  // vector types
  // ----------------------------------------

  // full multicast packet, key in [39:8], header in [7:0]
  typedef logic [39:0] pkt_t;

  // packet header byte
  typedef logic [7:0]  hdr_t;

  // routing key, virtual key on top, mapped address below
  typedef logic [31:0] key_t;

  // upper half of every routing key
  typedef logic [15:0] vkey_t;

  // raw address as sent by the sensor
  // retina layout: [6:0] x, [13:7] y, [14] polarity, [15] unused
  typedef logic [15:0] aer_addr_t;

  // one retina coordinate, x or y
  typedef logic [6:0]  coord_t;

  // virtual key select, 1 picks the alternate key
  typedef logic [0:0]  vks_t;

  // ----------------------------------------
  // mapping modes
  // ----------------------------------------

  // modes 2 and 3 behave as raw
  typedef enum logic [1:0] {
    MODE_RAW    = 2'd0,
    MODE_RETINA = 2'd1,
    MODE_2      = 2'd2,
    MODE_3      = 2'd3
  } mode_t;

  // ----------------------------------------
  // constants
  // ----------------------------------------

  // default and alternate virtual keys
  localparam vkey_t VKEY_DEF = 16'h0200;
  localparam vkey_t VKEY_ALT = 16'hFEFF;

  // select code for the alternate key
  localparam vks_t  VKS_ALT  = 1'b1;

  // multicast header, no payload and no parity
  localparam hdr_t  MC_HEADER = 8'h00;

  // go flag out of reset, events flow without a control packet
  localparam logic  INIT_GO = 1'b1;

  // go flag position inside a control packet
  localparam int    GO_BIT = 8;

  // retina field positions in the address
  localparam int    RET_X_LSB = 0;
  localparam int    RET_Y_LSB = 7;
  localparam int    RET_P_BIT = 14;

endpackage

`default_nettype wire

// ==== verilog/aer_if_top.sv ====
/*
 * AER sensor to SpiNNaker bridge top level
 * receiver, packet builder and control block
 */
`timescale 1ns/1ns
`default_nettype none

module aer_if_top (
  input  wire                        clk,
  input  wire                        rst,

  // AER sensor
  input  wire                        aer_req_n,
  input  wire aer_if_pkg::aer_addr_t aer_addr,
  output wire                        aer_ack_n,

  // control packets
  input  wire aer_if_pkg::pkt_t      cpkt_data,
  input  wire                        cpkt_vld,
  output wire                        cpkt_rdy,

  // static selects
  input  wire aer_if_pkg::mode_t     msel,
  input  wire aer_if_pkg::vks_t      vksel,

  // SpiNNaker packets
  output aer_if_pkg::pkt_t           opkt_data,
  output wire                        opkt_vld,
  input  wire                        opkt_rdy
);

  // ----------------------------------------
  // internal links
  // ----------------------------------------

  // receiver to builder
  aer_if_pkg::aer_addr_t evt_addr;
  logic                  evt_vld;
  logic                  evt_rdy;

  // control to builder
  aer_if_pkg::mode_t     vmode;
  aer_if_pkg::vkey_t     vkey;
  logic                  go;

  aer_in_sync u_in_sync (
    .clk       (clk),
    .rst       (rst),
    .aer_req_n (aer_req_n),
    .aer_addr  (aer_addr),
    .aer_ack_n (aer_ack_n),
    .evt_addr  (evt_addr),
    .evt_vld   (evt_vld),
    .evt_rdy   (evt_rdy)
  );

  aer_pkt_builder u_pkt_builder (
    .clk       (clk),
    .rst       (rst),
    .evt_addr  (evt_addr),
    .evt_vld   (evt_vld),
    .evt_rdy   (evt_rdy),
    .vmode     (vmode),
    .vkey      (vkey),
    .go        (go),
    .opkt_data (opkt_data),
    .opkt_vld  (opkt_vld),
    .opkt_rdy  (opkt_rdy)
  );

  aer_if_control u_control (
    .clk       (clk),
    .rst       (rst),
    .cpkt_data (cpkt_data),
    .cpkt_vld  (cpkt_vld),
    .cpkt_rdy  (cpkt_rdy),
    .msel      (msel),
    .vksel     (vksel),
    .vmode     (vmode),
    .vkey      (vkey),
    .go        (go)
  );

endmodule

`default_nettype wire

// ==== verilog/aer_in_sync.sv ====
/*
 * AER receiver: synchronizes the sensor request, captures the
 * address and runs the 4-phase ack once the event is taken
 */
`timescale 1ns/1ns
`default_nettype none

module aer_in_sync (
  input  wire                       clk,
  input  wire                       rst,

  // sensor side, active low
  input  wire                       aer_req_n,
  input  wire aer_if_pkg::aer_addr_t aer_addr,
  output logic                      aer_ack_n,

  // event to builder
  output aer_if_pkg::aer_addr_t     evt_addr,
  output logic                      evt_vld,
  input  wire                       evt_rdy
);

  typedef enum logic [1:0] {
    IDLE,
    OFFER,
    ACKED,
    RELEASE
  } state_t;

  state_t state;

  // request synchronizer and edge history
  logic req_s1;
  logic req_s2;
  logic req_d;
  logic req_fall;

  // ----------------------------------------
  // request synchronizer
  // ----------------------------------------

  // idle level of the request is high
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      req_s1 <= 1'b1;
      req_s2 <= 1'b1;
      req_d  <= 1'b1;
    end else begin
      req_s1 <= aer_req_n;
      req_s2 <= req_s1;
      req_d  <= req_s2;
    end
  end

  // new request seen after the second stage
  assign req_fall = req_d & ~req_s2;

  // address is stable by now, sender set it before req
  always_ff @(posedge clk) begin
    if (state == IDLE && req_fall)
      evt_addr <= aer_addr;
  end

  // ----------------------------------------
  // handshake FSM
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= IDLE;
      evt_vld   <= 1'b0;
      aer_ack_n <= 1'b1;
    end else begin
      case (state)
        // wait for a falling request
        IDLE: begin
          if (req_fall) begin
            evt_vld <= 1'b1;
            state   <= OFFER;
          end
        end
        // hold the event until the builder takes it
        OFFER: begin
          if (evt_rdy) begin
            evt_vld <= 1'b0;
            state   <= ACKED;
          end
        end
        // ack one edge after the transfer
        ACKED: begin
          aer_ack_n <= 1'b0;
          state     <= RELEASE;
        end
        // wait for the sender to drop its request
        RELEASE: begin
          if (req_s2) begin
            aer_ack_n <= 1'b1;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/aer_pkt_builder.sv ====
/*
 * packet builder: maps AER events to multicast routing keys,
 * drops events while go is low, one-entry output register
 */
`timescale 1ns/1ns
`default_nettype none

module aer_pkt_builder (
  input  wire                        clk,
  input  wire                        rst,

  // event from receiver
  input  wire aer_if_pkg::aer_addr_t evt_addr,
  input  wire                        evt_vld,
  output logic                       evt_rdy,

  // control
  input  wire aer_if_pkg::mode_t     vmode,
  input  wire aer_if_pkg::vkey_t     vkey,
  input  wire                        go,

  // packet out
  output aer_if_pkg::pkt_t           opkt_data,
  output logic                       opkt_vld,
  input  wire                        opkt_rdy
);

  import aer_if_pkg::*;

  // retina fields pulled from the address
  coord_t ret_x;
  coord_t ret_y;
  logic   ret_pol;

  // mapped key and the packet it becomes
  key_t   next_key;
  pkt_t   next_pkt;

  // handshake qualifiers
  logic   evt_take;
  logic   opkt_take;

  // ----------------------------------------
  // key mapping
  // ----------------------------------------

  assign ret_x   = evt_addr[RET_X_LSB +: 7];
  assign ret_y   = evt_addr[RET_Y_LSB +: 7];
  assign ret_pol = evt_addr[RET_P_BIT];

  // virtual key always on top
  always_comb begin
    case (vmode)
      // y, x, polarity packed low, top bit clear
      MODE_RETINA: next_key = {vkey, 1'b0, ret_y, ret_x, ret_pol};
      // raw and the spare modes
      default:     next_key = {vkey, evt_addr};
    endcase
  end

  // header goes in the low byte
  assign next_pkt = {next_key, MC_HEADER};

  // ----------------------------------------
  // output register
  // ----------------------------------------

  // room when empty or draining this edge
  assign evt_rdy   = ~opkt_vld | opkt_rdy;

  assign evt_take  = evt_vld & evt_rdy;
  assign opkt_take = opkt_vld & opkt_rdy;

  // valid flag, a gated event is taken but never loaded
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      opkt_vld <= 1'b0;
    end else begin
      if (evt_take && go)
        opkt_vld <= 1'b1;
      else if (opkt_take)
        opkt_vld <= 1'b0;
    end
  end

  // payload only moves on a real load
  always_ff @(posedge clk) begin
    if (evt_take && go)
      opkt_data <= next_pkt;
  end

endmodule

`default_nettype wire
